//--- ddr3_access_seq.sv
////////////////////
// DDR3 access sequencer: read, write, refresh with auto-precharge
////////////////////
`timescale 1ns/1ns

module ddr3_access_seq (
    input  logic                                               pclk,
    input  logic                                               rst_lock_n,
    input  logic                                               init_done,
    input  logic                                               rd,
    input  logic                                               wr,
    input  logic                                               refresh,
    input  logic [ddr3_pkg::addr_width-1:0]                    addr,
    input  logic [ddr3_pkg::word_width-1:0]                    din,
    input  logic [ddr3_pkg::beats*ddr3_pkg::word_width-1:0]    rd_beats,
    output logic                                               busy,
    output logic                                               data_ready,
    output logic [ddr3_pkg::word_width-1:0]                    dout,
    output logic [ddr3_pkg::beats*ddr3_pkg::word_width-1:0]    dout128,
    output logic [2:0]                                         acc_cmd,
    output logic [1:0]                                         acc_slot,
    output logic [ddr3_pkg::bank_width-1:0]                    acc_ba,
    output logic [ddr3_pkg::row_width-1:0]                     acc_a,
    output logic [ddr3_pkg::beats*ddr3_pkg::word_width-1:0]    dq_beats,
    output logic [0:3]                                         dq_oen,
    output logic [0:7]                                         dqs_beats,
    output logic [0:3]                                         dqs_oen,
    output logic [0:7]                                         dm_beats
);

    typedef enum logic [1:0] {st_idle, st_read, st_write, st_refresh} state_t;

    state_t                             state;
    logic [3:0]                         cycle;      // 1 right after the accept edge
    logic [ddr3_pkg::addr_width-1:0]    addr_q;
    logic [ddr3_pkg::word_width-1:0]    din_q;
    logic [ddr3_pkg::word_width-1:0]    dout_keep;
    logic [ddr3_pkg::word_width-1:0]    beat0;
    logic [1:0]                         word_sel;   // Word within the BC4 burst
    logic                               rw_req;
    logic                               accept;
    logic                               wr_data0;
    logic                               wr_data1;

    assign busy     = ~init_done | (state != st_idle);
    assign rw_req   = rd | wr;
    assign accept   = ~busy & (rw_req | refresh);   // rd/wr win over refresh
    assign word_sel = addr_q[1:0];
    assign wr_data0 = (state == st_write) && (cycle == 4'(ddr3_pkg::wr_data_cycle));
    assign wr_data1 = (state == st_write) && (cycle == 4'(ddr3_pkg::wr_data_cycle + 1));
    // Beat 0 sits at the top of the 128-bit word
    assign beat0    = rd_beats[ddr3_pkg::beats*ddr3_pkg::word_width-1 -: ddr3_pkg::word_width];
    assign dout128  = rd_beats;
    assign dout     = data_ready ? beat0 : dout_keep;

    // Command requests, registered later in the slot issuer
    always_comb begin
        acc_cmd  = ddr3_pkg::cmd_nop;
        acc_slot = '0;
        acc_ba   = '0;
        acc_a    = '0;
        if (accept && rw_req) begin
            acc_cmd = ddr3_pkg::cmd_activate;                       // Slot 0
            acc_ba  = addr[ddr3_pkg::addr_width-1 -: ddr3_pkg::bank_width];
            acc_a   = addr[ddr3_pkg::col_width +: ddr3_pkg::row_width];
        end else if (accept) begin
            acc_cmd = ddr3_pkg::cmd_refresh;                        // All banks already closed
        end else if ((state == st_read && cycle == 4'(ddr3_pkg::rd_cmd_cycle)) ||
                     (state == st_write && cycle == 4'(ddr3_pkg::wr_cmd_cycle))) begin
            acc_cmd  = (state == st_read) ? ddr3_pkg::cmd_read : ddr3_pkg::cmd_write;
            acc_slot = 2'(ddr3_pkg::rw_slot);                       // tRCD after ACTIVATE
            acc_ba   = addr_q[ddr3_pkg::addr_width-1 -: ddr3_pkg::bank_width];
            acc_a[ddr3_pkg::col_width-1:0] = addr_q[ddr3_pkg::col_width-1:0];
            acc_a[10] = 1'b1;                                       // Auto precharge
            acc_a[12] = (state == st_read);                         // BL8 read, BC4 write
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            state      <= st_idle;
            cycle      <= '0;
            data_ready <= 1'b0;
        end else begin
            cycle      <= cycle + 4'd1;
            data_ready <= 1'b0;
            case (state)
                st_idle: if (accept) begin
                    state <= rw_req ? (rd ? st_read : st_write) : st_refresh;
                    cycle <= 4'd1;
                end
                st_read: begin
                    // Registered, shows in cycle rd_ready_cycle
                    data_ready <= (cycle == 4'(ddr3_pkg::rd_ready_cycle - 1));
                    if (cycle == 4'(ddr3_pkg::rd_ready_cycle))
                        state <= st_idle;
                end
                st_write: if (cycle == 4'(ddr3_pkg::wr_done_cycle - 1))
                    state <= st_idle;
                default: if (cycle == 4'(ddr3_pkg::ref_done_cycle - 1))
                    state <= st_idle;
            endcase
        end
    end

    // Write strobes and mask, idle is all released and masked
    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            dq_oen   <= 4'b1111;
            dqs_oen  <= 4'b1111;
            dm_beats <= 8'hff;
        end else begin
            dq_oen   <= 4'b1111;
            dqs_oen  <= 4'b1111;
            dm_beats <= 8'hff;
            if (wr_data0) begin
                dq_oen      <= 4'b1110;
                dqs_oen     <= 4'b1110;                     // Preamble on the last pair
                dm_beats[7] <= (word_sel != 2'd0);
            end else if (wr_data1) begin
                dq_oen      <= 4'b0011;
                dqs_oen     <= 4'b0011;
                dm_beats[0] <= (word_sel != 2'd1);
                dm_beats[1] <= (word_sel != 2'd2);
                dm_beats[2] <= (word_sel != 2'd3);
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge pclk) begin
        if (accept) begin
            addr_q <= addr;
            din_q  <= din;
        end
        if (data_ready)
            dout_keep <= beat0;
        if (wr_data0) begin
            dqs_beats <= 8'b1111_1110;
            dq_beats  <= {{((ddr3_pkg::beats - 1) * ddr3_pkg::word_width){1'b0}}, din_q};
        end else if (wr_data1) begin
            dqs_beats <= 8'b1010_0000;                      // Two toggles then postamble
            dq_beats  <= {din_q, din_q, din_q,
                          {((ddr3_pkg::beats - 3) * ddr3_pkg::word_width){1'b0}}};
        end
    end

    // data_ready only ever comes out of a read in flight
    assert property (@(posedge pclk) disable iff (!rst_lock_n)
        data_ready |-> state != st_idle);

endmodule

//--- ddr3_controller.sv
////////////////////
// DDR3 controller top, sequencers and slot issuer
////////////////////
`timescale 1ns/1ns

module ddr3_controller (
    input  logic                                               pclk,
    input  logic                                               rst_lock_n,
    input  logic                                               rd,
    input  logic                                               wr,
    input  logic                                               refresh,
    input  logic [ddr3_pkg::addr_width-1:0]                    addr,
    input  logic [ddr3_pkg::word_width-1:0]                    din,
    input  logic [ddr3_pkg::beats*ddr3_pkg::word_width-1:0]    rd_beats,
    output logic                                               busy,
    output logic                                               data_ready,
    output logic [ddr3_pkg::word_width-1:0]                    dout,
    output logic [ddr3_pkg::beats*ddr3_pkg::word_width-1:0]    dout128,
    output logic                                               cke,
    output logic                                               ddr_reset_n,
    output logic                                               init_done,
    output logic [3*ddr3_pkg::slots-1:0]                       cmd_lanes,
    output logic [ddr3_pkg::row_width*ddr3_pkg::slots-1:0]     a_lanes,
    output logic [ddr3_pkg::bank_width*ddr3_pkg::slots-1:0]    ba_lanes,
    output logic [ddr3_pkg::beats*ddr3_pkg::word_width-1:0]    dq_beats,
    output logic [0:3]                                         dq_oen,
    output logic [0:7]                                         dqs_beats,
    output logic [0:3]                                         dqs_oen,
    output logic [0:7]                                         dm_beats
);

    // Init requests, slot 0 only
    logic [2:0]                         init_cmd;
    logic [ddr3_pkg::bank_width-1:0]    init_ba;
    logic [ddr3_pkg::row_width-1:0]     init_a;
    // Access requests
    logic [2:0]                         acc_cmd;
    logic [1:0]                         acc_slot;
    logic [ddr3_pkg::bank_width-1:0]    acc_ba;
    logic [ddr3_pkg::row_width-1:0]     acc_a;

    ddr3_init_seq ddr3_init_seq_i (
        .pclk(pclk), .rst_lock_n(rst_lock_n),
        .cke(cke), .ddr_reset_n(ddr_reset_n), .init_done(init_done),
        .init_cmd(init_cmd), .init_ba(init_ba), .init_a(init_a)
    );

    ddr3_access_seq ddr3_access_seq_i (
        .pclk(pclk), .rst_lock_n(rst_lock_n), .init_done(init_done),
        .rd(rd), .wr(wr), .refresh(refresh), .addr(addr), .din(din), .rd_beats(rd_beats),
        .busy(busy), .data_ready(data_ready), .dout(dout), .dout128(dout128),
        .acc_cmd(acc_cmd), .acc_slot(acc_slot), .acc_ba(acc_ba), .acc_a(acc_a),
        .dq_beats(dq_beats), .dq_oen(dq_oen), .dqs_beats(dqs_beats), .dqs_oen(dqs_oen),
        .dm_beats(dm_beats)
    );

    ddr3_slot_issue ddr3_slot_issue_i (
        .pclk(pclk), .rst_lock_n(rst_lock_n),
        .init_cmd(init_cmd), .init_ba(init_ba), .init_a(init_a),
        .acc_cmd(acc_cmd), .acc_slot(acc_slot), .acc_ba(acc_ba), .acc_a(acc_a),
        .cmd_lanes(cmd_lanes), .a_lanes(a_lanes), .ba_lanes(ba_lanes)
    );

endmodule

//--- ddr3_init_seq.sv
////////////////////
// DDR3 power-up sequencer: reset and CKE waits, MRS writes, ZQCL
////////////////////
`timescale 1ns/1ns

module ddr3_init_seq (
    input  logic                              pclk,
    input  logic                              rst_lock_n,
    output logic                              cke,
    output logic                              ddr_reset_n,
    output logic                              init_done,
    output logic [2:0]                        init_cmd,
    output logic [ddr3_pkg::bank_width-1:0]   init_ba,
    output logic [ddr3_pkg::row_width-1:0]    init_a
);

    typedef enum logic [2:0] {ph_reset, ph_cke, ph_config, ph_zq, ph_done} phase_t;

    phase_t      phase;
    logic [4:0]  count;        // Remaining cycles of the current wait
    logic [3:0]  cfg_cycle;    // Step within the MRS sequence
    logic [15:0] mr_word;
    logic        mrs_step_hit;

    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            phase       <= ph_reset;
            count       <= 5'(ddr3_pkg::reset_wait - 1);
            cfg_cycle   <= '0;
            cke         <= 1'b0;
            ddr_reset_n <= 1'b0;
            init_done   <= 1'b0;
        end else begin
            count <= (count == '0) ? '0 : count - 5'd1;
            case (phase)
                ph_reset: if (count == '0) begin
                    ddr_reset_n <= 1'b1;                 // Memory out of reset
                    count       <= 5'(ddr3_pkg::cke_wait - 1);
                    phase       <= ph_cke;
                end
                ph_cke: begin
                    if (count == 5'(ddr3_pkg::cke_lead))
                        cke <= 1'b1;
                    if (count == '0)
                        phase <= ph_config;
                end
                ph_config: begin
                    cfg_cycle <= cfg_cycle + 4'd1;
                    if (cfg_cycle == 4'(ddr3_pkg::zq_cycle)) begin  // ZQCL goes out now
                        count <= 5'(ddr3_pkg::zq_wait - 1);
                        phase <= ph_zq;
                    end
                end
                ph_zq: if (count == '0) begin
                    init_done <= 1'b1;
                    phase     <= ph_done;
                end
                default: phase <= ph_done;               // Stay here until reset
            endcase
        end
    end

    // MR2, MR3, MR1, MR0 every mrs_step cycles
    always_comb begin
        mrs_step_hit = 1'b1;
        case (cfg_cycle)
            4'(0):                      mr_word = ddr3_pkg::mr2;
            4'(ddr3_pkg::mrs_step):     mr_word = ddr3_pkg::mr3;
            4'(2 * ddr3_pkg::mrs_step): mr_word = ddr3_pkg::mr1;
            4'(3 * ddr3_pkg::mrs_step): mr_word = ddr3_pkg::mr0;
            default: begin
                mr_word      = '0;
                mrs_step_hit = 1'b0;
            end
        endcase
        init_cmd = ddr3_pkg::cmd_nop;
        init_ba  = '0;
        init_a   = '0;
        if (phase == ph_config && mrs_step_hit) begin
            init_cmd          = ddr3_pkg::cmd_mrs;
            {init_ba, init_a} = mr_word;
        end else if (phase == ph_config && cfg_cycle == 4'(ddr3_pkg::zq_cycle)) begin
            init_cmd   = ddr3_pkg::cmd_zqcl;
            init_a[10] = 1'b1;                           // Long calibration
        end
    end

    // CKE only goes high once the memory is out of reset
    assert property (@(posedge pclk) disable iff (!rst_lock_n) $rose(cke) |-> ddr_reset_n);

endmodule

//--- ddr3_pkg.sv
////////////////////
// DDR3 sequencer shared widths, timing, command codes
// and mode register words
////////////////////
package ddr3_pkg;

    // Address and data widths
    localparam int row_width  = 13;
    localparam int col_width  = 10;
    localparam int bank_width = 3;
    localparam int addr_width = bank_width + row_width + col_width;  // {bank, row, col}
    localparam int word_width = 16;
    localparam int slots      = 4;         // Memory clocks per pclk
    localparam int beats      = 8;         // DQ beats per pclk

    // DDR3-800 timing in memory clocks
    localparam int t_cas      = 6;
    localparam int t_cwl      = 5;
    localparam int t_rcd      = 6;
    localparam int t_rc       = 20;
    localparam int t_mrd      = 8;
    localparam int t_mod      = 12;
    localparam int serdes_lat = 16;        // PHY out and back

    // Power-up waits in pclk cycles, cut down for simulation
    localparam int reset_wait = 20;
    localparam int cke_wait   = 20;
    localparam int cke_lead   = 15;        // Leaves tXPR before the first MRS
    localparam int zq_wait    = 3;

    // Config cycles of the MRS writes and the ZQCL
    localparam int mrs_step   = t_mrd / 4;
    localparam int zq_cycle   = 3 * mrs_step + t_mod / 4 + 1;

    // Commands as {RAS#, CAS#, WE#}
    localparam logic [2:0] cmd_mrs       = 3'b000;
    localparam logic [2:0] cmd_refresh   = 3'b001;
    localparam logic [2:0] cmd_precharge = 3'b010;
    localparam logic [2:0] cmd_activate  = 3'b011;
    localparam logic [2:0] cmd_write     = 3'b100;
    localparam logic [2:0] cmd_read      = 3'b101;
    localparam logic [2:0] cmd_zqcl      = 3'b110;
    localparam logic [2:0] cmd_nop       = 3'b111;

    // Mode register fields
    localparam logic [1:0] m_bl        = 2'b01;    // BC4 or BL8 on the fly
    localparam logic [3:0] m_cas       = 4'b0100;  // CL 6
    localparam logic [2:0] m_cwl       = 3'b000;   // CWL 5
    localparam logic [2:0] m_wr        = 3'b010;   // WR 6
    localparam logic       m_dll_reset = 1'b1;
    localparam logic [2:0] m_rtt_nom   = 3'b000;   // Off, single rank
    localparam logic [1:0] m_rtt_wr    = 2'b00;    // Off
    localparam logic [1:0] m_drive     = 2'b00;    // Low drive
    localparam logic [1:0] m_al        = 2'b00;

    // Mode register words, {BA, A}
    localparam logic [15:0] mr0 = {3'b000, 1'b0, m_wr, m_dll_reset, 1'b0, m_cas[3:1], 1'b0,
                                   m_cas[0], m_bl};
    localparam logic [15:0] mr1 = {3'b001, 3'b000, m_rtt_nom[2], 2'b00, m_rtt_nom[1],
                                   m_drive[1], m_al, m_rtt_nom[0], m_drive[0], 1'b0};
    localparam logic [15:0] mr2 = {3'b010, 2'b00, m_rtt_wr, 3'b000, m_cwl, 3'b000};
    localparam logic [15:0] mr3 = {3'b011, 13'b0};

    // Access schedule in pclk cycles, counted from 1 after the accept edge
    localparam int rw_slot        = t_rcd % slots;                        // Slot 2
    localparam int rd_cmd_cycle   = t_rcd / 4;
    localparam int wr_cmd_cycle   = t_rcd / 4;
    localparam int rd_ready_cycle = (t_rcd + t_cas + serdes_lat) / 4 + 1;
    localparam int wr_data_cycle  = (t_rcd + t_cwl) / 4;
    localparam int wr_done_cycle  = t_rc / 4;
    localparam int ref_done_cycle = t_rc / 4;

endpackage

//--- ddr3_slot_issue.sv
////////////////////
// DDR3 slot issuer: init and access requests into four command lanes
////////////////////
`timescale 1ns/1ns

module ddr3_slot_issue (
    input  logic                                              pclk,
    input  logic                                              rst_lock_n,
    input  logic [2:0]                                        init_cmd,
    input  logic [ddr3_pkg::bank_width-1:0]                   init_ba,
    input  logic [ddr3_pkg::row_width-1:0]                    init_a,
    input  logic [2:0]                                        acc_cmd,
    input  logic [1:0]                                        acc_slot,
    input  logic [ddr3_pkg::bank_width-1:0]                   acc_ba,
    input  logic [ddr3_pkg::row_width-1:0]                    acc_a,
    output logic [3*ddr3_pkg::slots-1:0]                      cmd_lanes,
    output logic [ddr3_pkg::row_width*ddr3_pkg::slots-1:0]    a_lanes,
    output logic [ddr3_pkg::bank_width*ddr3_pkg::slots-1:0]   ba_lanes
);

    logic [3*ddr3_pkg::slots-1:0]                      cmd_nxt;
    logic [ddr3_pkg::row_width*ddr3_pkg::slots-1:0]    a_nxt;
    logic [ddr3_pkg::bank_width*ddr3_pkg::slots-1:0]   ba_nxt;
    logic                                              init_req;
    logic                                              acc_req;

    assign init_req = (init_cmd != ddr3_pkg::cmd_nop);
    assign acc_req  = (acc_cmd != ddr3_pkg::cmd_nop);

    // Lane i holds memory clock i of this pclk, lane 0 at the LSBs
    always_comb begin
        cmd_nxt = {ddr3_pkg::slots{ddr3_pkg::cmd_nop}};
        a_nxt   = '0;
        ba_nxt  = '0;
        if (init_req) begin                                  // Init always uses slot 0
            cmd_nxt[2:0]                         = init_cmd;
            a_nxt[ddr3_pkg::row_width-1:0]       = init_a;
            ba_nxt[ddr3_pkg::bank_width-1:0]     = init_ba;
        end else if (acc_req) begin
            cmd_nxt[3*acc_slot +: 3]                                  = acc_cmd;
            a_nxt[ddr3_pkg::row_width*acc_slot +: ddr3_pkg::row_width]    = acc_a;
            ba_nxt[ddr3_pkg::bank_width*acc_slot +: ddr3_pkg::bank_width] = acc_ba;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_lock_n) begin
            cmd_lanes <= {ddr3_pkg::slots{ddr3_pkg::cmd_nop}};
            a_lanes   <= '0;
            ba_lanes  <= '0;
        end else begin
            cmd_lanes <= cmd_nxt;
            a_lanes   <= a_nxt;
            ba_lanes  <= ba_nxt;
        end
    end

    // Accesses start only after init is done, so the requesters never overlap
    assert property (@(posedge pclk) disable iff (!rst_lock_n) !(init_req && acc_req));

endmodule

//--- ddr3_stim.txt
# op (R read, W write, F refresh)  addr {bank,row,col}  write word  read beats 0..7
# all fields hex
W 0000000 a5a5 00000000000000000000000000000000
R 0000000 0000 1111222233334444555566667777888a
W 1234561 beef 00000000000000000000000000000000
F 0000000 0000 00000000000000000000000000000000
R 1234561 0000 beef0001000200030004000500060007
W 3ffffe2 0f0f 00000000000000000000000000000000
W 2abc403 c3c3 00000000000000000000000000000000
R 2abc403 0000 c3c3ffffeeeeddddccccbbbbaaaa9999
F 0000000 0000 00000000000000000000000000000000
R 0800bff 0000 0123456789abcdeffedcba9876543210
W 155aa5a 7e57 00000000000000000000000000000000
F 0000000 0000 00000000000000000000000000000000
R 3ffffff 0000 ffff0000ffff0000ffff0000ffff0000
W 0400001 0001 00000000000000000000000000000000
R 0400001 0000 0001deadbeefcafe8badf00d12345678
F 0000000 0000 00000000000000000000000000000000

//--- filelist.f
ddr3_pkg.sv
ddr3_init_seq.sv
ddr3_access_seq.sv
ddr3_slot_issue.sv
ddr3_controller.sv
tb_ddr3_controller.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the DDR3 controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ddr3_controller \
    -f filelist.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- tb_ddr3_controller.sv
////////////////////
// DDR3 controller testbench, ops and expected data from the stim file
////////////////////
`timescale 1ns/1ns

module tb_ddr3_controller;

    localparam int init_cycles = 100;        // Reset, power-up waits and MRS sequence
    localparam logic [11:0] all_nop = 12'hfff;

    logic          pclk;
    logic          rst_lock_n;
    logic          rd;
    logic          wr;
    logic          refresh;
    logic [25:0]   addr;
    logic [15:0]   din;
    logic [127:0]  rd_beats;
    logic          busy;
    logic          data_ready;
    logic [15:0]   dout;
    logic [127:0]  dout128;
    logic          cke;
    logic          ddr_reset_n;
    logic          init_done;
    logic [11:0]   cmd_lanes;
    logic [51:0]   a_lanes;
    logic [11:0]   ba_lanes;
    logic [127:0]  dq_beats;
    logic [0:3]    dq_oen;
    logic [0:7]    dqs_beats;
    logic [0:3]    dqs_oen;
    logic [0:7]    dm_beats;

    // Stimulus table
    string         op_q[$];
    logic [25:0]   addr_q[$];
    logic [15:0]   word_q[$];
    logic [127:0]  beats_q[$];
    int            cycles;
    int            limit;

    ddr3_controller ddr3_controller_i (.*);

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    // Watchdog
    always @(posedge pclk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // Lanes with one command, NOP and zero everywhere else
    task automatic check_lanes(input int slot, input logic [2:0] c,
                               input logic [12:0] a, input logic [2:0] ba);
        logic [11:0] c_exp;
        logic [51:0] a_exp;
        logic [11:0] ba_exp;
        c_exp  = all_nop;
        a_exp  = '0;
        ba_exp = '0;
        if (c != ddr3_pkg::cmd_nop) begin
            c_exp[3*slot +: 3]   = c;
            a_exp[13*slot +: 13] = a;
            ba_exp[3*slot +: 3]  = ba;
        end
        check_val("cmd_lanes", cmd_lanes, c_exp);
        check_val("a_lanes", a_lanes, a_exp);
        check_val("ba_lanes", ba_lanes, ba_exp);
    endtask

    task automatic check_idle_lanes();
        check_lanes(0, ddr3_pkg::cmd_nop, '0, '0);
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        string line;
        string op;
        logic [31:0]  a;
        logic [15:0]  w;
        logic [127:0] b;
        fd = $fopen("ddr3_stim.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the stimulus file ddr3_stim.txt");
            $display("Testbench failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%s %h %h %h", op, a, w, b);
                if (n == 4) begin
                    op_q.push_back(op);
                    addr_q.push_back(a[25:0]);
                    word_q.push_back(w);
                    beats_q.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_init();
        int k;
        for (k = 1; k <= 20; k++) begin             // Memory reset release
            @(negedge pclk);
            check_val("ddr_reset_n", ddr_reset_n, k == 20);
            check_val("cke", cke, 1'b0);
        end
        for (k = 1; k <= 5; k++) begin              // 15 cycles of CKE wait left
            @(negedge pclk);
            check_val("cke", cke, k == 5);
        end
        while (cmd_lanes == all_nop)
            @(negedge pclk);
        for (k = 0; k <= 10; k++) begin
            if (k > 0)
                @(negedge pclk);
            case (k)
                0:  check_lanes(0, ddr3_pkg::cmd_mrs, ddr3_pkg::mr2[12:0], ddr3_pkg::mr2[15:13]);
                2:  check_lanes(0, ddr3_pkg::cmd_mrs, ddr3_pkg::mr3[12:0], ddr3_pkg::mr3[15:13]);
                4:  check_lanes(0, ddr3_pkg::cmd_mrs, ddr3_pkg::mr1[12:0], ddr3_pkg::mr1[15:13]);
                6:  check_lanes(0, ddr3_pkg::cmd_mrs, ddr3_pkg::mr0[12:0], ddr3_pkg::mr0[15:13]);
                10: check_lanes(0, ddr3_pkg::cmd_zqcl, 13'h0400, 3'd0);    // A10 long cal
                default: check_idle_lanes();
            endcase
            check_val("init_done", init_done, 1'b0);
            check_val("busy", busy, 1'b1);
        end
        for (k = 1; k <= 3; k++) begin              // ZQ wait
            @(negedge pclk);
            check_idle_lanes();
            check_val("init_done", init_done, k == 3);
            check_val("busy", busy, k != 3);
        end
    endtask

    task automatic run_read(input logic [25:0] a, input logic [127:0] b);
        int j;
        rd       = 1'b1;
        addr     = a;
        rd_beats = b;
        for (j = 0; j <= 9; j++) begin
            @(negedge pclk);
            if (j == 0)
                check_lanes(0, ddr3_pkg::cmd_activate, a[22:10], a[25:23]);
            else if (j == 1)
                check_lanes(2, ddr3_pkg::cmd_read, {3'b101, a[9:0]}, a[25:23]);  // BL8, AP
            else
                check_idle_lanes();                 // No ACTIVATE from the ignored rd
            check_val("data_ready", data_ready, j == 7);
            check_val("busy", busy, j < 8);
            if (j >= 7)
                check_val("dout", dout, b[127:112]);
            if (j == 7)
                check_val("dout128", dout128, b);
            if (j == 9)
                check_val("dout128", dout128, ~b);
            rd = (j == 1);                          // Raised again while busy
            if (j == 8)
                rd_beats = ~b;                      // dout must hold the captured beat
        end
    endtask

    task automatic run_write(input logic [25:0] a, input logic [15:0] w);
        int         j;
        int         beat;
        logic [0:7] dm_exp;
        wr   = 1'b1;
        addr = a;
        din  = w;
        beat = (a[1:0] == 2'd0) ? 7 : int'(a[1:0]) - 1;    // Burst word to beat 7,0,1,2
        for (j = 0; j <= 4; j++) begin
            @(negedge pclk);
            wr     = 1'b0;
            dm_exp = 8'hff;
            if (j == 0)
                check_lanes(0, ddr3_pkg::cmd_activate, a[22:10], a[25:23]);
            else if (j == 1)
                check_lanes(2, ddr3_pkg::cmd_write, {3'b001, a[9:0]}, a[25:23]);  // BC4, AP
            else
                check_idle_lanes();
            if (j == 2) begin
                dm_exp[7] = (beat != 7);
                check_val("dq_oen", dq_oen, 4'b1110);
                check_val("dqs_oen", dqs_oen, 4'b1110);
                check_val("dqs_beats", dqs_beats, 8'b1111_1110);
                check_val("dq_beats", dq_beats, {112'b0, w});
            end else if (j == 3) begin
                if (beat != 7)
                    dm_exp[beat] = 1'b0;
                check_val("dq_oen", dq_oen, 4'b0011);
                check_val("dqs_oen", dqs_oen, 4'b0011);
                check_val("dqs_beats", dqs_beats, 8'b1010_0000);
                check_val("dq_beats", dq_beats, {w, w, w, 80'b0});
            end else begin
                check_val("dq_oen", dq_oen, 4'b1111);
                check_val("dqs_oen", dqs_oen, 4'b1111);
            end
            check_val("dm_beats", dm_beats, dm_exp);
            check_val("busy", busy, j < 4);
        end
    endtask

    task automatic run_refresh();
        int j;
        refresh = 1'b1;
        for (j = 0; j <= 4; j++) begin
            @(negedge pclk);
            refresh = 1'b0;
            if (j == 0)
                check_lanes(0, ddr3_pkg::cmd_refresh, '0, '0);
            else
                check_idle_lanes();
            check_val("busy", busy, j < 4);
        end
    endtask

    initial begin
        int i;
        rst_lock_n = 1'b0;
        rd         = 1'b0;
        wr         = 1'b0;
        refresh    = 1'b0;
        addr       = '0;
        din        = '0;
        rd_beats   = '0;
        limit      = 0;
        load_stim();
        limit = init_cycles + 12 * op_q.size();
        for (i = 1; i <= 16; i++) begin
            @(negedge pclk);
            check_val("busy", busy, 1'b1);
            check_val("cke", cke, 1'b0);
            check_val("ddr_reset_n", ddr_reset_n, 1'b0);
            check_val("data_ready", data_ready, 1'b0);
            check_val("dq_oen", dq_oen, 4'b1111);
            check_val("dqs_oen", dqs_oen, 4'b1111);
            check_val("dm_beats", dm_beats, 8'hff);
            check_idle_lanes();
        end
        rst_lock_n = 1'b1;
        check_init();
        foreach (op_q[n]) begin
            while (busy)
                @(negedge pclk);
            case (op_q[n])
                "R": run_read(addr_q[n], beats_q[n]);
                "W": run_write(addr_q[n], word_q[n]);
                "F": run_refresh();
                default: check_val("opcode", 0, 1);     // Unknown op letter in the file
            endcase
        end
        $display("Testbench passed");
        $finish;
    end

endmodule
